// ==== verilog/rvfi_pkg.sv ====
package rvfi_pkg;

  // base data width of the traced core
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [1:0]      priv_mode_t;
  typedef logic [3:0]      mem_mask_t;
  typedef logic [15:0]     order_t;

  // one retired instruction as reported by the core
  typedef struct packed {
    xlen_t      pc;
    xlen_t      insn;
    reg_addr_t  rd_addr;
    xlen_t      rd_wdata;
    xlen_t      mem_addr;
    mem_mask_t  mem_rmask;
    mem_mask_t  mem_wmask;
    logic       trap;
    priv_mode_t mode;
  } retire_t;

  // record as carried through the trace buffer
  typedef struct packed {
    retire_t ret;
    order_t  order;
    // set on the first record stored after a drop
    logic    overflow;
  } rvfi_rec_t;

endpackage

// ==== verilog/trace_pkg.sv ====
package trace_pkg;

  typedef logic [31:0] trace_word_t;

  // record buffer sizing
  localparam int TRACE_FIFO_DEPTH = 8;
  localparam int FIFO_IDX_W       = $clog2(TRACE_FIFO_DEPTH);

  // extra msb is the wrap bit
  typedef logic [FIFO_IDX_W:0] fifo_ptr_t;
  typedef logic [15:0]         drop_cnt_t;

  typedef enum logic [2:0] {
    IDLE,
    HEADER,
    PC,
    INSN,
    RD,
    MEM
  } pkt_state_e;

  // header, pc and insn are always sent
  localparam int PKT_MIN_WORDS = 3;

  // header word layout
  localparam int HDR_ORDER_LSB = 0;
  localparam int HDR_ORDER_MSB = 15;
  localparam int HDR_COUNT_LSB = 16;
  localparam int HDR_COUNT_MSB = 19;
  localparam int HDR_TRAP_BIT  = 20;
  localparam int HDR_OVF_BIT   = 21;
  localparam int HDR_MODE_LSB  = 22;
  localparam int HDR_MODE_MSB  = 23;
  localparam int HDR_RD_LSB    = 24;
  localparam int HDR_RD_MSB    = 28;

endpackage

// ==== verilog/rvfi_collector.sv ====
module rvfi_collector import rvfi_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,

  input  logic      trace_en_i,
  input  logic      retire_valid_i,
  input  retire_t   retire_i,

  output logic      rec_valid_o,
  output rvfi_rec_t rec_o
);

  logic    accept;
  order_t  order_q;
  retire_t retire_clean;

  // retirements are only traced while enabled
  assign accept = trace_en_i & retire_valid_i;

  // a trapped instruction has no architectural side effects
  always_comb begin
    retire_clean = retire_i;
    if (retire_i.trap) begin
      retire_clean.rd_addr   = '0;
      retire_clean.rd_wdata  = '0;
      retire_clean.mem_rmask = '0;
      retire_clean.mem_wmask = '0;
    end else if (retire_i.rd_addr == '0) begin
      // writes to x0 are discarded by the core
      retire_clean.rd_wdata = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rec_valid_o <= 1'b0;
      order_q     <= '0;
    end else begin
      rec_valid_o <= accept;
      if (accept) begin
        order_q <= order_q + order_t'(1);
      end
    end
  end

  // record payload, qualified by rec_valid_o
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rec_o.ret      <= retire_clean;
      rec_o.order    <= order_q;
      // the buffer sets this when it had to drop
      rec_o.overflow <= 1'b0;
    end
  end

endmodule

// ==== verilog/trace_fifo.sv ====
module trace_fifo import rvfi_pkg::*; import trace_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,

  input  logic      push_i,
  input  rvfi_rec_t push_rec_i,

  input  logic      pop_i,
  output logic      head_valid_o,
  output rvfi_rec_t head_rec_o,

  output drop_cnt_t drop_count_o
);

  rvfi_rec_t mem_q [TRACE_FIFO_DEPTH];
  fifo_ptr_t wr_ptr_q;
  fifo_ptr_t rd_ptr_q;
  logic      empty;
  logic      full;
  logic      push_ok;
  logic      pop_ok;
  logic      drop;
  logic      ovf_q;
  drop_cnt_t drop_cnt_q;
  rvfi_rec_t wr_rec;

  // same index, wrap bits tell full from empty
  assign empty = (wr_ptr_q == rd_ptr_q);
  assign full  = (wr_ptr_q[FIFO_IDX_W] != rd_ptr_q[FIFO_IDX_W]) &&
                 (wr_ptr_q[FIFO_IDX_W-1:0] == rd_ptr_q[FIFO_IDX_W-1:0]);

  assign pop_ok  = pop_i & ~empty;
  // a pop frees the slot in the same cycle
  assign push_ok = push_i & (~full | pop_ok);
  assign drop    = push_i & ~push_ok;

  // first stored record after a loss carries the flag
  always_comb begin
    wr_rec          = push_rec_i;
    wr_rec.overflow = ovf_q;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      ovf_q      <= 1'b0;
      drop_cnt_q <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= wr_ptr_q + fifo_ptr_t'(1);
      end
      if (pop_ok) begin
        rd_ptr_q <= rd_ptr_q + fifo_ptr_t'(1);
      end
      if (drop) begin
        ovf_q <= 1'b1;
      end else if (push_ok) begin
        ovf_q <= 1'b0;
      end
      // saturate rather than wrap
      if (drop && (drop_cnt_q != '1)) begin
        drop_cnt_q <= drop_cnt_q + drop_cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q[FIFO_IDX_W-1:0]] <= wr_rec;
    end
  end

  assign head_valid_o = ~empty;
  assign head_rec_o   = mem_q[rd_ptr_q[FIFO_IDX_W-1:0]];
  assign drop_count_o = drop_cnt_q;

endmodule

// ==== verilog/trace_packetizer.sv ====
module trace_packetizer import rvfi_pkg::*; import trace_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,

  input  logic        rec_valid_i,
  input  rvfi_rec_t   rec_i,
  output logic        pop_o,

  output logic        trace_valid_o,
  output logic        trace_last_o,
  output trace_word_t trace_word_o
);

  pkt_state_e  state_q;
  pkt_state_e  state_d;
  rvfi_rec_t   rec_q;
  logic        has_rd;
  logic        has_mem;
  logic [3:0]  word_cnt;
  trace_word_t header;

  // take a new record only between packets
  assign pop_o = (state_q == IDLE) & rec_valid_i;

  // optional words
  assign has_rd  = (rec_q.ret.rd_addr != '0);
  assign has_mem = (rec_q.ret.mem_rmask != '0) || (rec_q.ret.mem_wmask != '0);

  assign word_cnt = 4'(PKT_MIN_WORDS) + {3'b000, has_rd} + {3'b000, has_mem};

  always_comb begin
    header                              = '0;
    header[HDR_ORDER_MSB:HDR_ORDER_LSB] = rec_q.order;
    header[HDR_COUNT_MSB:HDR_COUNT_LSB] = word_cnt;
    header[HDR_TRAP_BIT]                = rec_q.ret.trap;
    header[HDR_OVF_BIT]                 = rec_q.overflow;
    header[HDR_MODE_MSB:HDR_MODE_LSB]   = rec_q.ret.mode;
    header[HDR_RD_MSB:HDR_RD_LSB]       = rec_q.ret.rd_addr;
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (rec_valid_i) begin
          state_d = HEADER;
        end
      end
      HEADER: state_d = PC;
      PC:     state_d = INSN;
      INSN: begin
        if (has_rd) begin
          state_d = RD;
        end else if (has_mem) begin
          state_d = MEM;
        end else begin
          state_d = IDLE;
        end
      end
      RD:      state_d = has_mem ? MEM : IDLE;
      MEM:     state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // record held for the whole packet
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      rec_q <= rec_i;
    end
  end

  // one word per state, the idle state emits nothing
  always_comb begin
    trace_valid_o = 1'b1;
    trace_last_o  = 1'b0;
    trace_word_o  = '0;
    unique case (state_q)
      HEADER: trace_word_o = header;
      PC:     trace_word_o = rec_q.ret.pc;
      INSN: begin
        trace_word_o = rec_q.ret.insn;
        trace_last_o = ~has_rd & ~has_mem;
      end
      RD: begin
        trace_word_o = rec_q.ret.rd_wdata;
        trace_last_o = ~has_mem;
      end
      MEM: begin
        trace_word_o = rec_q.ret.mem_addr;
        trace_last_o = 1'b1;
      end
      default: trace_valid_o = 1'b0;
    endcase
  end

endmodule

// ==== verilog/trace_top.sv ====
module trace_top import rvfi_pkg::*; import trace_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,

  // retirement port of the core
  input  logic        trace_en_i,
  input  logic        retire_valid_i,
  input  retire_t     retire_i,

  // trace word stream
  output logic        trace_valid_o,
  output trace_word_t trace_word_o,
  output logic        trace_last_o,
  output drop_cnt_t   drop_count_o
);

  logic      rec_valid;
  rvfi_rec_t rec;
  logic      fifo_valid;
  rvfi_rec_t fifo_rec;
  logic      fifo_pop;

  rvfi_collector i_collector (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .trace_en_i     (trace_en_i),
    .retire_valid_i (retire_valid_i),
    .retire_i       (retire_i),
    .rec_valid_o    (rec_valid),
    .rec_o          (rec)
  );

  trace_fifo i_fifo (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_i       (rec_valid),
    .push_rec_i   (rec),
    .pop_i        (fifo_pop),
    .head_valid_o (fifo_valid),
    .head_rec_o   (fifo_rec),
    .drop_count_o (drop_count_o)
  );

  trace_packetizer i_packetizer (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .rec_valid_i   (fifo_valid),
    .rec_i         (fifo_rec),
    .pop_o         (fifo_pop),
    .trace_valid_o (trace_valid_o),
    .trace_last_o  (trace_last_o),
    .trace_word_o  (trace_word_o)
  );

endmodule

// ==== dv/trace_top_sva.sv ====
module trace_top_sva import trace_pkg::*; (
  input logic        clk_i,
  input logic        rst_n_i,
  // fifo head valid as seen by the packetizer
  input logic        pop_i,
  input logic        head_valid_i,
  input logic        trace_valid_i,
  input logic        trace_last_i,
  input trace_word_t trace_word_i
);

  logic [3:0] seen_q;
  logic [3:0] count_q;
  logic [3:0] count_now;

  // packet length comes from the header, held for the rest of the packet
  assign count_now = (seen_q == 4'd0) ? trace_word_i[HDR_COUNT_MSB:HDR_COUNT_LSB] : count_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      seen_q  <= '0;
      count_q <= '0;
    end else if (trace_valid_i) begin
      count_q <= count_now;
      seen_q  <= trace_last_i ? 4'd0 : seen_q + 4'd1;
    end
  end

  pop_needs_head: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) pop_i |-> head_valid_i
  ) else $error("pop while the buffer head is not valid");

  last_needs_valid: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) trace_last_i |-> trace_valid_i
  ) else $error("trace_last_o raised without trace_valid_o");

  last_matches_count: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
      (trace_valid_i && trace_last_i) |-> (seen_q + 4'd1 == count_now)
  ) else $error("packet ended on a word other than the header count");

endmodule

bind trace_packetizer trace_top_sva i_trace_top_sva (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .pop_i         (pop_o),
  .head_valid_i  (rec_valid_i),
  .trace_valid_i (trace_valid_o),
  .trace_last_i  (trace_last_o),
  .trace_word_i  (trace_word_o)
);

// ==== dv/tb_trace_top.sv ====
module tb_trace_top import rvfi_pkg::*; import trace_pkg::*; ();

  logic        clk_i = 1'b0;
  logic        rst_n_i;
  logic        trace_en_i;
  logic        retire_valid_i;
  retire_t     retire_i;
  logic        trace_valid_o;
  trace_word_t trace_word_o;
  logic        trace_last_o;
  drop_cnt_t   drop_count_o;

  int          mismatches = 0;
  int          failures = 0;
  int          headers_seen = 0;
  logic [3:0]  pkt_words = '0;
  logic [3:0]  hdr_count;
  order_t      exp_order;
  logic        pending_ovf;
  logic        capture;
  trace_word_t exp_words[$];
  logic        exp_last[$];
  trace_word_t obs_words[$];

  trace_top i_trace_top (.*);

  always #2 clk_i = ~clk_i;

  task automatic compare_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      mismatches++;
      $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic push_word(input trace_word_t w, input logic last);
    exp_words.push_back(w);
    exp_last.push_back(last);
  endtask

  // reference packet for one accepted retirement
  task automatic queue_packet(input retire_t r, input order_t ord, input logic ovf);
    trace_word_t hdr;
    logic        has_rd;
    logic        has_mem;
    if (r.trap) begin
      r.rd_addr   = '0;
      r.mem_rmask = '0;
      r.mem_wmask = '0;
    end
    has_rd  = (r.rd_addr != 5'd0);
    has_mem = (r.mem_rmask != 4'd0) || (r.mem_wmask != 4'd0);
    hdr = '0;
    hdr[HDR_ORDER_MSB:HDR_ORDER_LSB] = ord;
    hdr[HDR_COUNT_MSB:HDR_COUNT_LSB] = 4'd3 + 4'(has_rd) + 4'(has_mem);
    hdr[HDR_TRAP_BIT]                = r.trap;
    hdr[HDR_OVF_BIT]                 = ovf;
    hdr[HDR_MODE_MSB:HDR_MODE_LSB]   = r.mode;
    hdr[HDR_RD_MSB:HDR_RD_LSB]       = r.rd_addr;
    push_word(hdr, 1'b0);
    push_word(r.pc, 1'b0);
    push_word(r.insn, !has_rd && !has_mem);
    if (has_rd) begin
      push_word(r.rd_wdata, !has_mem);
    end
    if (has_mem) begin
      push_word(r.mem_addr, 1'b1);
    end
  endtask

  function automatic retire_t make_retire(input xlen_t pc, input xlen_t insn, input reg_addr_t rd,
                                          input mem_mask_t rmask, input mem_mask_t wmask,
                                          input logic trap);
    retire_t r;
    r           = '0;
    r.pc        = pc;
    r.insn      = insn;
    r.rd_addr   = rd;
    r.rd_wdata  = ~insn;
    r.mem_addr  = pc + 32'h100;
    r.mem_rmask = rmask;
    r.mem_wmask = wmask;
    r.trap      = trap;
    r.mode      = 2'b11;
    return r;
  endfunction

  task automatic send_retire(input retire_t r, input logic en);
    @(posedge clk_i);
    trace_en_i     <= en;
    retire_valid_i <= 1'b1;
    retire_i       <= r;
    if (en) begin
      if (!capture) begin
        queue_packet(r, exp_order, pending_ovf);
        pending_ovf = 1'b0;
      end
      exp_order = exp_order + order_t'(1);
    end
  endtask

  task automatic end_retire();
    @(posedge clk_i);
    retire_valid_i <= 1'b0;
  endtask

  // done when collector, buffer and packetizer are all empty
  task automatic wait_drained();
    int   cycles;
    logic quiet;
    cycles = 0;
    quiet  = 1'b0;
    while (!quiet && cycles < 300) begin
      @(negedge clk_i);
      quiet = !i_trace_top.rec_valid && !i_trace_top.fifo_valid && !trace_valid_o;
      cycles++;
    end
    if (!quiet) begin
      failures++;
      $display("ERROR at %0t: trace pipeline did not drain within 300 cycles", $time);
    end else if (exp_words.size() != 0) begin
      failures++;
      $display("ERROR at %0t: %0d expected trace words never appeared", $time, exp_words.size());
    end
  endtask

  always @(negedge clk_i) begin
    if (rst_n_i && trace_valid_o) begin
      if (pkt_words == 4'd0) begin
        hdr_count = trace_word_o[HDR_COUNT_MSB:HDR_COUNT_LSB];
        headers_seen++;
      end
      pkt_words = pkt_words + 4'd1;
      if (trace_last_o) begin
        compare_value("header word count", 32'(hdr_count), 32'(pkt_words));
        pkt_words = 4'd0;
      end
      if (capture) begin
        obs_words.push_back(trace_word_o);
      end else if (exp_words.size() == 0) begin
        failures++;
        $display("ERROR at %0t: trace word %h arrived with no packet expected", $time, trace_word_o);
      end else begin
        compare_value("trace_word_o", exp_words.pop_front(), trace_word_o);
        compare_value("trace_last_o", 32'(exp_last.pop_front()), 32'(trace_last_o));
      end
    end
  end

  task automatic test_plain_alu();
    send_retire(make_retire(32'h8000_0000, 32'h0000_0013, 5'd0, 4'h0, 4'h0, 1'b0), 1'b1);
    end_retire();
    wait_drained();
  endtask

  task automatic test_full_and_trap();
    send_retire(make_retire(32'h8000_0100, 32'h0002_a283, 5'd5, 4'hf, 4'h0, 1'b0), 1'b1);
    end_retire();
    wait_drained();
    send_retire(make_retire(32'h8000_0104, 32'h0062_a023, 5'd7, 4'h0, 4'h3, 1'b0), 1'b1);
    end_retire();
    wait_drained();
    send_retire(make_retire(32'h8000_0100, 32'h0002_a283, 5'd5, 4'hf, 4'h0, 1'b1), 1'b1);
    end_retire();
    wait_drained();
  endtask

  task automatic test_order_and_enable();
    for (int i = 0; i < 7; i++) begin
      // two disabled strobes in the middle of the run
      send_retire(make_retire(32'h0000_2000 + (32'(i) << 2), 32'h0010_0093, 5'd1, 4'h0, 4'h0,
                              1'b0), (i != 3) && (i != 4));
    end
    end_retire();
    wait_drained();
  endtask

  task automatic test_overflow();
    order_t      base;
    order_t      prev;
    order_t      ord;
    trace_word_t hdr;
    drop_cnt_t   drops_before;
    int          heads_before;
    int          packets;
    int          ovf_seen;
    capture = 1'b1;
    obs_words.delete();
    base         = exp_order;
    drops_before = drop_count_o;
    heads_before = headers_seen;
    for (int i = 0; i < 20; i++) begin
      send_retire(make_retire(32'h0000_1000 + (32'(i) << 2), 32'h0000_0013, 5'd0, 4'h0, 4'h0,
                              1'b0), 1'b1);
    end
    end_retire();
    wait_drained();
    capture = 1'b0;
    packets = headers_seen - heads_before;
    if (packets >= 20) begin
      failures++;
      $display("ERROR: a burst of 20 records did not overflow the buffer");
    end
    compare_value("drop_count_o", 32'(drops_before) + 32'(20 - packets), 32'(drop_count_o));
    if (obs_words.size() != 3 * packets) begin
      failures++;
      $display("ERROR: burst packets were not all three words long");
    end
    prev     = base - order_t'(1);
    ovf_seen = 0;
    for (int p = 0; 3 * p + 2 < obs_words.size(); p++) begin
      hdr = obs_words[3 * p];
      ord = hdr[HDR_ORDER_MSB:HDR_ORDER_LSB];
      // surviving records keep their order and stay inside the burst
      if ((ord - base > order_t'(19)) || (p > 0 && ord - base <= prev - base)) begin
        failures++;
        $display("ERROR at %0t: burst order number %0d is out of sequence", $time, ord);
      end
      // a gap in the order numbers means records were dropped before this one
      queue_packet(make_retire(32'h0000_1000 + (32'(ord - base) << 2), 32'h0000_0013, 5'd0,
                               4'h0, 4'h0, 1'b0), ord, ord != prev + order_t'(1));
      if (ord != prev + order_t'(1)) begin
        ovf_seen++;
      end
      for (int j = 0; j < 3; j++) begin
        compare_value("trace_word_o", exp_words[j], obs_words[3 * p + j]);
      end
      exp_words.delete();
      exp_last.delete();
      prev = ord;
    end
    if (ovf_seen == 0) begin
      failures++;
      $display("ERROR: no record after the drops carried the overflow flag");
    end
    // drops at the end of the burst tag the next stored record
    pending_ovf = (prev != base + order_t'(19));
  endtask

  task automatic test_random_mix();
    retire_t r;
    int      kind;
    for (int i = 0; i < 40; i++) begin
      r           = '0;
      r.pc        = $urandom() & 32'hffff_fffc;
      r.insn      = $urandom();
      r.rd_addr   = ($urandom() % 4 == 0) ? 5'd0 : 5'($urandom());
      r.rd_wdata  = $urandom();
      r.mem_addr  = $urandom();
      kind        = int'($urandom() % 3);
      r.mem_rmask = (kind == 1) ? (4'($urandom()) | 4'h1) : 4'h0;
      r.mem_wmask = (kind == 2) ? (4'($urandom()) | 4'h1) : 4'h0;
      r.trap      = ($urandom() % 8 == 0);
      r.mode      = 2'($urandom());
      send_retire(r, 1'b1);
      end_retire();
      // longest packet plus its idle cycle fits in the gap
      repeat (4 + $urandom() % 4) @(posedge clk_i);
    end
    wait_drained();
  endtask

  initial begin
    rst_n_i        = 1'b0;
    trace_en_i     = 1'b0;
    retire_valid_i = 1'b0;
    retire_i       = '0;
    exp_order      = '0;
    pending_ovf    = 1'b0;
    capture        = 1'b0;
    void'($urandom(32'h2ccd));
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    compare_value("trace_valid_o", 32'd0, 32'(trace_valid_o));
    compare_value("trace_last_o", 32'd0, 32'(trace_last_o));
    compare_value("drop_count_o", 32'd0, 32'(drop_count_o));
    compare_value("fifo_pop", 32'd0, 32'(i_trace_top.fifo_pop));
    test_plain_alu();
    test_full_and_trap();
    test_order_and_enable();
    test_overflow();
    test_random_mix();
    $display("tb_trace_top: %0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
verilog/rvfi_pkg.sv
verilog/trace_pkg.sv
verilog/rvfi_collector.sv
verilog/trace_fifo.sv
verilog/trace_packetizer.sv
verilog/trace_top.sv
dv/trace_top_sva.sv
dv/tb_trace_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f build.f --top-module tb_trace_top -o sim_trace_top

# the simulator may stop early on an assertion, so the log decides
./obj_dir/sim_trace_top | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
